// ==== rtl/pcu_pkg.sv ====
// Performance counter unit shared definitions
// SPR bus types, event encoding and PCMR bit layout
package pcu_pkg;

  // SPR address, upper five bits group and low eleven bits offset
  typedef logic [15:0] spr_addr_t;
  typedef logic [4:0]  spr_grp_t;
  typedef logic [10:0] spr_off_t;

  // SPR data word, also the counter width
  typedef logic [31:0] spr_data_t;

  // Event order from bit 0 upward:
  // load, store, ifetch, dcache miss, icache miss, ifetch stall,
  // LSU stall, branch stall, DTLB miss, ITLB miss, data-dependency stall
  typedef logic [10:0] pcu_event_t;

  // Index into the counter bank
  typedef logic [2:0] cnt_idx_t;

  // Counter group and its two register windows
  localparam spr_grp_t PCU_SPR_GROUP = spr_grp_t'(7);
  localparam spr_off_t PCCR_BASE     = spr_off_t'(0);
  localparam spr_off_t PCMR_BASE     = spr_off_t'(8);

  // Largest bank that cnt_idx_t can address
  localparam int MAX_COUNTERS = 8;

  // PCMR bit positions
  localparam int PCMR_CP      = 0;
  localparam int PCMR_UMRA    = 1;
  localparam int PCMR_CISM    = 2;
  localparam int PCMR_CIUM    = 3;
  localparam int PCMR_EVT_LSB = 4;

  // Highest software-writable PCMR bit
  localparam int PCMR_WR_MSB = 25;

  // Writable bits PCMR_WR_MSB down to UMRA
  localparam spr_data_t PCMR_WR_MASK =
    spr_data_t'((64'd1 << (PCMR_WR_MSB + 1)) - (64'd1 << PCMR_UMRA));

  // Counter present only, so nothing is counted after reset
  localparam spr_data_t PCMR_RST_VAL = spr_data_t'(1) << PCMR_CP;

endpackage

// ==== rtl/pcu_ctrl_if.sv ====
// Control link between the SPR register block and the counter bank
// Carries per-counter event masks and modes, the counter write port
// and the current counter values
`timescale 1ns/100ps

interface pcu_ctrl_if #(
  parameter int NUM_COUNTERS = 8
);

  // Event select per counter, straight from PCMR
  pcu_pkg::pcu_event_t [NUM_COUNTERS-1:0] evt_mask;

  // Bit 0 counts in supervisor mode, bit 1 in user mode
  logic [NUM_COUNTERS-1:0][1:0] cnt_mode;

  // PCCR write port
  logic                cnt_we;
  pcu_pkg::cnt_idx_t   cnt_idx;
  pcu_pkg::spr_data_t  cnt_wdata;

  // Live counter values for SPR reads
  pcu_pkg::spr_data_t [NUM_COUNTERS-1:0] cnt_rd;

  modport regs (
    output evt_mask, cnt_mode, cnt_we, cnt_idx, cnt_wdata,
    input  cnt_rd
  );

  modport bank (
    input  evt_mask, cnt_mode, cnt_we, cnt_idx, cnt_wdata,
    output cnt_rd
  );

endinterface

// ==== rtl/pcu_spr_regs.sv ====
// SPR front end of the performance counter unit
// Decodes PCCR/PCMR accesses, holds the mode registers, applies
// the privilege rules and builds the read data
`timescale 1ns/100ps

module pcu_spr_regs #(
  parameter int NUM_COUNTERS = 8
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               spr_access_i,
  input  logic               spr_we_i,
  input  logic               spr_re_i,
  input  logic               spr_sys_mode_i,
  input  pcu_pkg::spr_addr_t spr_addr_i,
  input  pcu_pkg::spr_data_t spr_dat_i,
  output logic               spr_ack_o,
  output pcu_pkg::spr_data_t spr_dat_o,
  pcu_ctrl_if.regs           ctrl
);

  // Bank size has to fit the index type
  if (NUM_COUNTERS < 1 || NUM_COUNTERS > pcu_pkg::MAX_COUNTERS) begin : g_bad_cfg
    $error("pcu_spr_regs: NUM_COUNTERS out of range");
  end

  pcu_pkg::spr_grp_t  spr_grp;
  pcu_pkg::spr_off_t  spr_off;
  pcu_pkg::spr_off_t  pccr_rel;
  pcu_pkg::spr_off_t  pcmr_rel;
  pcu_pkg::cnt_idx_t  pccr_idx;
  pcu_pkg::cnt_idx_t  pcmr_idx;
  logic               grp_hit;
  logic               pccr_hit;
  logic               pcmr_hit;
  logic               pcmr_wr;
  pcu_pkg::spr_data_t rd_data;

  pcu_pkg::spr_data_t pcmr_q [NUM_COUNTERS];

  assign spr_grp = spr_addr_i[15:11];
  assign spr_off = spr_addr_i[10:0];
  assign grp_hit = (spr_grp == pcu_pkg::PCU_SPR_GROUP);

  // Offsets below a base wrap to large values and miss
  assign pccr_rel = spr_off - pcu_pkg::PCCR_BASE;
  assign pcmr_rel = spr_off - pcu_pkg::PCMR_BASE;
  assign pccr_idx = pcu_pkg::cnt_idx_t'(pccr_rel);
  assign pcmr_idx = pcu_pkg::cnt_idx_t'(pcmr_rel);

  assign pccr_hit = grp_hit && (pccr_rel < pcu_pkg::spr_off_t'(NUM_COUNTERS));
  assign pcmr_hit = grp_hit && (pcmr_rel < pcu_pkg::spr_off_t'(NUM_COUNTERS));

  // Writes need supervisor mode
  assign pcmr_wr = spr_access_i && spr_we_i && spr_sys_mode_i && pcmr_hit;

  // Only the writable field changes, CP keeps its reset one
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_COUNTERS; i++) begin
        pcmr_q[i] <= pcu_pkg::PCMR_RST_VAL;
      end
    end else if (pcmr_wr) begin
      for (int i = 0; i < NUM_COUNTERS; i++) begin
        if (pcmr_idx == pcu_pkg::cnt_idx_t'(i)) begin
          pcmr_q[i] <= (pcmr_q[i] & ~pcu_pkg::PCMR_WR_MASK) |
                       (spr_dat_i & pcu_pkg::PCMR_WR_MASK);
        end
      end
    end
  end

  // Mode register fields out to the counter bank
  always_comb begin
    for (int i = 0; i < NUM_COUNTERS; i++) begin
      ctrl.evt_mask[i] = pcmr_q[i][pcu_pkg::PCMR_EVT_LSB +: $bits(pcu_pkg::pcu_event_t)];
      ctrl.cnt_mode[i] = {pcmr_q[i][pcu_pkg::PCMR_CIUM], pcmr_q[i][pcu_pkg::PCMR_CISM]};
    end
  end

  // Counter writes go straight to the bank
  assign ctrl.cnt_we    = spr_access_i && spr_we_i && spr_sys_mode_i && pccr_hit;
  assign ctrl.cnt_idx   = pccr_idx;
  assign ctrl.cnt_wdata = spr_dat_i;

  // PCCR readable in any mode, PCMR only in supervisor mode
  always_comb begin
    rd_data = '0;
    if (spr_access_i && spr_re_i) begin
      if (pccr_hit) begin
        rd_data = ctrl.cnt_rd[pccr_idx];
      end else if (pcmr_hit && spr_sys_mode_i) begin
        rd_data = pcmr_q[pcmr_idx];
      end
    end
  end

  // No back-pressure, every access is acked at once
  assign spr_ack_o = spr_access_i;
  assign spr_dat_o = rd_data;

  a_we_re_excl : assert property (
    @(posedge clk) disable iff (rst)
    spr_access_i |-> !(spr_we_i && spr_re_i)
  );

endmodule

// ==== rtl/pcu_counter_bank.sv ====
// Performance counter array
// Each counter adds one per cycle when any selected event fires in an
// enabled privilege mode; an SPR write replaces that cycle's count
`timescale 1ns/100ps

module pcu_counter_bank #(
  parameter int NUM_COUNTERS = 8
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                spr_sys_mode_i,
  input  pcu_pkg::pcu_event_t pcu_event_i,
  pcu_ctrl_if.bank            ctrl
);

  pcu_pkg::spr_data_t      cnt_q [NUM_COUNTERS];
  logic [NUM_COUNTERS-1:0] evt_hit;
  logic [NUM_COUNTERS-1:0] mode_ok;
  logic [NUM_COUNTERS-1:0] cnt_inc;
  logic [NUM_COUNTERS-1:0] cnt_wr;

  always_comb begin
    for (int i = 0; i < NUM_COUNTERS; i++) begin
      // Several events in one cycle still count once
      evt_hit[i] = |(pcu_event_i & ctrl.evt_mask[i]);
      mode_ok[i] = spr_sys_mode_i ? ctrl.cnt_mode[i][0] : ctrl.cnt_mode[i][1];
      cnt_inc[i] = evt_hit[i] && mode_ok[i];
      cnt_wr[i]  = ctrl.cnt_we && (ctrl.cnt_idx == pcu_pkg::cnt_idx_t'(i));
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_COUNTERS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_COUNTERS; i++) begin
        // Write wins, the increment is dropped
        if (cnt_wr[i]) begin
          cnt_q[i] <= ctrl.cnt_wdata;
        end else if (cnt_inc[i]) begin
          cnt_q[i] <= cnt_q[i] + pcu_pkg::spr_data_t'(1);
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_COUNTERS; i++) begin
      ctrl.cnt_rd[i] = cnt_q[i];
    end
  end

  // The register block must only target counters that exist
  a_idx_range : assert property (
    @(posedge clk) disable iff (rst)
    ctrl.cnt_we |-> (int'(ctrl.cnt_idx) < NUM_COUNTERS)
  );

endmodule

// ==== rtl/pcu_top.sv ====
// Performance counter unit top level
// SPR bus and event inputs as plain ports; the register block and
// the counter bank talk over pcu_ctrl_if
`timescale 1ns/100ps

module pcu_top #(
  parameter int NUM_COUNTERS = 8
) (
  input  logic                clk,
  input  logic                rst,

  // SPR bus
  input  logic                spr_access_i,
  input  logic                spr_we_i,
  input  logic                spr_re_i,
  input  pcu_pkg::spr_addr_t  spr_addr_i,
  input  pcu_pkg::spr_data_t  spr_dat_i,
  input  logic                spr_sys_mode_i,
  output logic                spr_ack_o,
  output pcu_pkg::spr_data_t  spr_dat_o,

  // Registered pipeline events
  input  pcu_pkg::pcu_event_t pcu_event_i
);

  pcu_ctrl_if #(
    .NUM_COUNTERS (NUM_COUNTERS)
  ) ctrl_if ();

  pcu_spr_regs #(
    .NUM_COUNTERS (NUM_COUNTERS)
  ) i_spr_regs (
    .clk            (clk),
    .rst            (rst),
    .spr_access_i   (spr_access_i),
    .spr_we_i       (spr_we_i),
    .spr_re_i       (spr_re_i),
    .spr_sys_mode_i (spr_sys_mode_i),
    .spr_addr_i     (spr_addr_i),
    .spr_dat_i      (spr_dat_i),
    .spr_ack_o      (spr_ack_o),
    .spr_dat_o      (spr_dat_o),
    .ctrl           (ctrl_if.regs)
  );

  pcu_counter_bank #(
    .NUM_COUNTERS (NUM_COUNTERS)
  ) i_counter_bank (
    .clk            (clk),
    .rst            (rst),
    .spr_sys_mode_i (spr_sys_mode_i),
    .pcu_event_i    (pcu_event_i),
    .ctrl           (ctrl_if.bank)
  );

endmodule

// ==== verif/pcu_clk_gen.sv ====
// Clock and reset source for the performance counter testbench
// 10 ns clock, synchronous reset held for a fixed number of cycles
`timescale 1ns/100ps

module pcu_clk_gen #(
  parameter int RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

// ==== verif/pcu_tb.sv ====
// Directed testbench for the performance counter unit
// Keeps a software copy of PCCR/PCMR and checks every SPR cycle against it
`timescale 1ns/100ps

module pcu_tb;

  localparam int NUM_CNT      = 8;
  localparam int RESET_CYCLES = 16;
  localparam int BURST_LEN    = 200;
  localparam int SUP_CYCLES   = 20;
  localparam int USR_CYCLES   = 30;

  // Cycle budget of each test, used by the watchdog
  localparam int TOTAL_CYCLES = RESET_CYCLES + (2 * NUM_CNT + 2) + (7 * NUM_CNT + 1) +
                                (4 * NUM_CNT + BURST_LEN) + (9 + SUP_CYCLES + USR_CYCLES) +
                                (8 + NUM_CNT);

  localparam logic [4:0]         CNT_GROUP = 5'd7;
  localparam pcu_pkg::spr_data_t WR_MASK   = 32'h03FF_FFFE;

  logic                clk;
  logic                rst;
  logic                spr_access_i;
  logic                spr_we_i;
  logic                spr_re_i;
  pcu_pkg::spr_addr_t  spr_addr_i;
  pcu_pkg::spr_data_t  spr_dat_i;
  logic                spr_sys_mode_i;
  logic                spr_ack_o;
  pcu_pkg::spr_data_t  spr_dat_o;
  pcu_pkg::pcu_event_t pcu_event_i;

  pcu_pkg::spr_data_t model_pccr [NUM_CNT];
  pcu_pkg::spr_data_t model_pcmr [NUM_CNT];
  int data_errors;
  int ack_errors;

  pcu_clk_gen #(
    .RESET_CYCLES (RESET_CYCLES)
  ) i_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  pcu_top #(
    .NUM_COUNTERS (NUM_CNT)
  ) i_pcu_top (
    .clk            (clk),
    .rst            (rst),
    .spr_access_i   (spr_access_i),
    .spr_we_i       (spr_we_i),
    .spr_re_i       (spr_re_i),
    .spr_addr_i     (spr_addr_i),
    .spr_dat_i      (spr_dat_i),
    .spr_sys_mode_i (spr_sys_mode_i),
    .spr_ack_o      (spr_ack_o),
    .spr_dat_o      (spr_dat_o),
    .pcu_event_i    (pcu_event_i)
  );

  function automatic pcu_pkg::spr_addr_t pccr_addr(input int n);
    return {CNT_GROUP, 11'(n)};
  endfunction

  function automatic pcu_pkg::spr_addr_t pcmr_addr(input int n);
    return {CNT_GROUP, 11'(8 + n)};
  endfunction

  // Read value per the register rules, from the model state
  function automatic pcu_pkg::spr_data_t expected_read(input pcu_pkg::spr_addr_t addr,
                                                       input logic sys);
    if (addr[15:11] != CNT_GROUP) begin
      return '0;
    end
    if (addr[10:0] < 11'd8) begin
      return model_pccr[addr[2:0]];
    end
    if (addr[10:0] < 11'd16 && sys) begin
      return model_pcmr[addr[2:0]];
    end
    return '0;
  endfunction

  // Counting uses the PCMR values from before this cycle's write
  task automatic model_update(input logic wr, input pcu_pkg::spr_addr_t addr,
                              input pcu_pkg::spr_data_t wdata, input logic sys,
                              input pcu_pkg::pcu_event_t evt);
    logic mode_en;
    for (int n = 0; n < NUM_CNT; n++) begin
      mode_en = sys ? model_pcmr[n][2] : model_pcmr[n][3];
      if (mode_en && ((model_pcmr[n][14:4] & evt) != '0)) begin
        model_pccr[n] = model_pccr[n] + 32'd1;
      end
    end
    if (wr && sys && addr[15:11] == CNT_GROUP) begin
      if (addr[10:0] < 11'd8) begin
        model_pccr[addr[2:0]] = wdata;
      end else if (addr[10:0] < 11'd16) begin
        model_pcmr[addr[2:0]] = (model_pcmr[addr[2:0]] & ~WR_MASK) | (wdata & WR_MASK);
      end
    end
  endtask

  task automatic check_data(input string name, input pcu_pkg::spr_data_t exp,
                            input pcu_pkg::spr_data_t act);
    if (act !== exp) begin
      data_errors++;
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_ack(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      ack_errors++;
      $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  // One bus cycle, entered and left 1 ns after a rising edge
  task automatic run_cycle(input logic access, input logic we, input logic re,
                           input pcu_pkg::spr_addr_t addr, input pcu_pkg::spr_data_t wdata,
                           input logic sys, input pcu_pkg::pcu_event_t evt,
                           input pcu_pkg::spr_data_t exp_rd);
    spr_access_i   = access;
    spr_we_i       = we;
    spr_re_i       = re;
    spr_addr_i     = addr;
    spr_dat_i      = wdata;
    spr_sys_mode_i = sys;
    pcu_event_i    = evt;
    @(negedge clk);
    check_ack("spr_ack_o", access, spr_ack_o);
    check_data("spr_dat_o", exp_rd, spr_dat_o);
    model_update(access && we, addr, wdata, sys, evt);
    @(posedge clk);
    #1;
    spr_access_i = 1'b0;
    spr_we_i     = 1'b0;
    spr_re_i     = 1'b0;
  endtask

  task automatic spr_write(input pcu_pkg::spr_addr_t addr, input pcu_pkg::spr_data_t data,
                           input logic sys);
    run_cycle(1'b1, 1'b1, 1'b0, addr, data, sys, '0, '0);
  endtask

  task automatic spr_read_check(input pcu_pkg::spr_addr_t addr, input logic sys,
                                input pcu_pkg::spr_data_t exp);
    run_cycle(1'b1, 1'b0, 1'b1, addr, '0, sys, '0, exp);
  endtask

  task automatic read_vs_model(input pcu_pkg::spr_addr_t addr, input logic sys);
    spr_read_check(addr, sys, expected_read(addr, sys));
  endtask

  task automatic event_burst(input int len, input logic rand_sys, input logic sys,
                             input logic all_events);
    logic [31:0]         rnd;
    pcu_pkg::pcu_event_t evt;
    logic                mode;
    for (int c = 0; c < len; c++) begin
      rnd  = $urandom;
      evt  = all_events ? 11'h7FF : pcu_pkg::pcu_event_t'(rnd);
      mode = rand_sys ? rnd[31] : sys;
      run_cycle(1'b0, 1'b0, 1'b0, '0, '0, mode, evt, '0);
    end
  endtask

  task automatic reset_values();
    for (int n = 0; n < NUM_CNT; n++) begin
      spr_read_check(pccr_addr(n), 1'b1, 32'd0);
      spr_read_check(pcmr_addr(n), 1'b1, 32'd1);
    end
    // Access without a read qualifier still acks with zero data
    run_cycle(1'b1, 1'b0, 1'b0, pccr_addr(0), '0, 1'b1, '0, '0);
    run_cycle(1'b0, 1'b0, 1'b0, '0, '0, 1'b1, '0, '0);
  endtask

  task automatic privilege_rules();
    pcu_pkg::spr_data_t val;
    for (int n = 0; n < NUM_CNT; n++) begin
      val = $urandom;
      spr_write(pccr_addr(n), val, 1'b1);
      spr_read_check(pccr_addr(n), 1'b1, val);
      spr_write(pcmr_addr(n), 32'hFFFF_FFFF, 1'b1);
      // User mode writes are dropped
      spr_write(pccr_addr(n), ~val, 1'b0);
      spr_write(pcmr_addr(n), 32'h0, 1'b0);
      spr_read_check(pccr_addr(n), 1'b0, val);
      spr_read_check(pcmr_addr(n), 1'b0, 32'h0);
    end
    spr_read_check(pcmr_addr(0), 1'b1, 32'h03FF_FFFF);
  endtask

  task automatic random_event_counting();
    logic [31:0]         rnd;
    pcu_pkg::pcu_event_t mask;
    for (int n = 0; n < NUM_CNT; n++) begin
      rnd  = $urandom;
      mask = (n == 0) ? 11'h001 : (n == NUM_CNT - 1) ? 11'h7FF : pcu_pkg::pcu_event_t'(rnd);
      spr_write(pcmr_addr(n), {17'b0, mask, 4'b1100}, 1'b1);
      read_vs_model(pcmr_addr(n), 1'b1);
      spr_write(pccr_addr(n), 32'd0, 1'b1);
    end
    event_burst(BURST_LEN, 1'b1, 1'b1, 1'b0);
    for (int n = 0; n < NUM_CNT; n++) begin
      read_vs_model(pccr_addr(n), 1'b1);
    end
  endtask

  task automatic mode_gating();
    spr_write(pcmr_addr(0), {17'b0, 11'h7FF, 4'b0100}, 1'b1);
    spr_write(pcmr_addr(1), {17'b0, 11'h7FF, 4'b1000}, 1'b1);
    spr_write(pcmr_addr(2), {17'b0, 11'h7FF, 4'b0000}, 1'b1);
    for (int n = 0; n < 3; n++) begin
      spr_write(pccr_addr(n), 32'd0, 1'b1);
    end
    event_burst(SUP_CYCLES, 1'b0, 1'b1, 1'b1);
    event_burst(USR_CYCLES, 1'b0, 1'b0, 1'b1);
    spr_read_check(pccr_addr(0), 1'b1, 32'(SUP_CYCLES));
    spr_read_check(pccr_addr(1), 1'b1, 32'(USR_CYCLES));
    spr_read_check(pccr_addr(2), 1'b1, 32'd0);
  endtask

  task automatic write_override_decode();
    spr_write(pcmr_addr(4), {17'b0, 11'h7FF, 4'b1100}, 1'b1);
    run_cycle(1'b1, 1'b1, 1'b0, pccr_addr(4), 32'h1234_5678, 1'b1, 11'h7FF, '0);
    spr_read_check(pccr_addr(4), 1'b1, 32'h1234_5678);
    // Other groups and offsets past the PCMR window
    spr_read_check({5'd6, 11'd0}, 1'b1, 32'd0);
    spr_read_check({5'd8, 11'd0}, 1'b1, 32'd0);
    spr_read_check({CNT_GROUP, 11'd16}, 1'b1, 32'd0);
    spr_read_check({CNT_GROUP, 11'h7FF}, 1'b1, 32'd0);
    spr_write({CNT_GROUP, 11'd16}, 32'hFFFF_FFFF, 1'b1);
    for (int n = 0; n < NUM_CNT; n++) begin
      read_vs_model(pccr_addr(n), 1'b1);
    end
  endtask

  initial begin
    spr_access_i   = 1'b0;
    spr_we_i       = 1'b0;
    spr_re_i       = 1'b0;
    spr_addr_i     = '0;
    spr_dat_i      = '0;
    spr_sys_mode_i = 1'b1;
    pcu_event_i    = '0;
    data_errors    = 0;
    ack_errors     = 0;
    void'($urandom(89076));
    for (int n = 0; n < NUM_CNT; n++) begin
      model_pccr[n] = 32'd0;
      model_pcmr[n] = 32'd1;
    end
    @(negedge rst);
    @(posedge clk);
    #1;
    reset_values();
    privilege_rules();
    random_event_counting();
    mode_gating();
    write_override_decode();
    $display("Check summary: %0d data errors, %0d ack errors", data_errors, ack_errors);
    if (data_errors == 0 && ack_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    repeat (2 * TOTAL_CYCLES) @(posedge clk);
    $display("Timeout: tests did not finish within %0d cycles", 2 * TOTAL_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== pcu.f ====
rtl/pcu_pkg.sv
rtl/pcu_ctrl_if.sv
rtl/pcu_spr_regs.sv
rtl/pcu_counter_bank.sv
rtl/pcu_top.sv
verif/pcu_clk_gen.sv
verif/pcu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the performance counter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module pcu_tb -f pcu.f -o pcu_sim

sim_out=$(./obj_dir/pcu_sim) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "^Simulation passed$"; then
  exit 0
else
  echo "Run did not report a pass"
  exit 1
fi
